/* hdl/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register count
`define RN_ARCH_REGS 32

// physical register count, must exceed RN_ARCH_REGS
`define RN_PHYS_REGS 64

// register data width
`define RN_XLEN 32

`endif

/* hdl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

`include "rename_config.svh"

    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_idx_t;
    typedef logic [`RN_XLEN-1:0]              data_t;

    // uop entering rename
    typedef struct packed {
        logic      valid;
        arch_idx_t rd1;
        arch_idx_t rd2;
        arch_idx_t wr;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        phys_idx_t phys_rd1;
        phys_idx_t phys_rd2;
        logic      rdy1;
        logic      rdy2;
        data_t     val1;
        data_t     val2;
        phys_idx_t phys_wr;
    } rename_rsp_t;

    // result ring writeback
    typedef struct packed {
        logic      valid;
        phys_idx_t phys;
        data_t     value;
    } ring_wb_t;

    // in-order retirement from the ROB
    typedef struct packed {
        logic      valid;
        arch_idx_t arch;
        phys_idx_t new_phys;
        phys_idx_t old_phys;
    } rob_commit_t;

endpackage

`default_nettype wire

/* hdl/rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_map import rename_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  rename_req_t req,
    input  phys_idx_t   alloc_phys,

    input  rob_commit_t commit,
    input  logic        rollback,

    output phys_idx_t   phys_rd1,
    output phys_idx_t   phys_rd2
);

    // speculative view, updated at rename
    phys_idx_t spec_map [`RN_ARCH_REGS];

    // committed view, updated at retirement
    phys_idx_t comm_map     [`RN_ARCH_REGS];
    phys_idx_t comm_map_nxt [`RN_ARCH_REGS];

    always_comb begin
        comm_map_nxt = comm_map;
        if (commit.valid) begin
            comm_map_nxt[commit.arch] = commit.new_phys;
        end
    end

    // identity mapping out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] <= phys_idx_t'(i);
                comm_map[i] <= phys_idx_t'(i);
            end
        end else begin
            comm_map <= comm_map_nxt;
            if (rollback) begin
                // a same-cycle commit is already part of the copy
                spec_map <= comm_map_nxt;
            end else if (req.valid) begin
                spec_map[req.wr] <= alloc_phys;
            end
        end
    end

    // sources see the map before this uop's own write
    always_ff @(posedge clk) begin
        phys_rd1 <= spec_map[req.rd1];
        phys_rd2 <= spec_map[req.rd2];
    end

    // issue and rollback are exclusive on the producer side
    a_no_req_on_rollback: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(rollback && req.valid)
    ) else $error("rename_map: req.valid asserted together with rollback");

endmodule

`default_nettype wire

/* hdl/phys_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module phys_free_list import rename_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        alloc,
    input  rob_commit_t commit,
    input  logic        rollback,

    output phys_idx_t   next_free,
    output logic        none_free
);

    // a set bit means the register is free
    logic [`RN_PHYS_REGS-1:0] spec_free;
    logic [`RN_PHYS_REGS-1:0] spec_free_nxt;
    logic [`RN_PHYS_REGS-1:0] comm_free;
    logic [`RN_PHYS_REGS-1:0] comm_free_nxt;

    // lowest free index wins
    always_comb begin
        next_free = '0;
        for (int i = `RN_PHYS_REGS - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                next_free = phys_idx_t'(i);
            end
        end
    end

    assign none_free = ~|spec_free;

    always_comb begin
        comm_free_nxt = comm_free;
        spec_free_nxt = spec_free;
        if (commit.valid) begin
            comm_free_nxt[commit.new_phys] = 1'b0;
            comm_free_nxt[commit.old_phys] = 1'b1;
            spec_free_nxt[commit.old_phys] = 1'b1;
        end
        if (alloc) begin
            spec_free_nxt[next_free] = 1'b0;
        end
        if (rollback) begin
            spec_free_nxt = comm_free_nxt;
        end
    end

    // arch registers start allocated, the rest free
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                spec_free[i] <= (i >= `RN_ARCH_REGS);
                comm_free[i] <= (i >= `RN_ARCH_REGS);
            end
        end else begin
            spec_free <= spec_free_nxt;
            comm_free <= comm_free_nxt;
        end
    end

    a_no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        alloc |-> !none_free
    ) else $error("phys_free_list: allocation with no free register");

    // retirement must release a register the committed state still owns
    a_no_double_free: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit.valid |-> !comm_free[commit.old_phys]
    ) else $error("phys_free_list: commit frees p%0d twice", commit.old_phys);

endmodule

`default_nettype wire

/* hdl/phys_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module phys_reg_file import rename_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    input  logic      alloc,
    input  phys_idx_t alloc_phys,

    input  phys_idx_t rd1,
    input  phys_idx_t rd2,

    input  ring_wb_t  wb,
    input  logic      rollback,

    output logic      rdy1,
    output logic      rdy2,
    output data_t     val1,
    output data_t     val2
);

    data_t                    regs [`RN_PHYS_REGS];
    logic [`RN_PHYS_REGS-1:0] ready;

    logic bypass1;
    logic bypass2;

    assign bypass1 = wb.valid && (wb.phys == rd1);
    assign bypass2 = wb.valid && (wb.phys == rd2);

    // values start at zero so the identity mapping reads clean
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.phys] <= wb.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= '1;
        end else if (rollback) begin
            // speculative producers are gone
            ready <= '1;
        end else begin
            if (wb.valid) begin
                ready[wb.phys] <= 1'b1;
            end
            if (alloc) begin
                ready[alloc_phys] <= 1'b0;
            end
        end
    end

    // registered reads, same-cycle writeback forwarded
    always_ff @(posedge clk) begin
        if (bypass1) begin
            rdy1 <= 1'b1;
            val1 <= wb.value;
        end else begin
            rdy1 <= ready[rd1];
            val1 <= regs[rd1];
        end
        if (bypass2) begin
            rdy2 <= 1'b1;
            val2 <= wb.value;
        end else begin
            rdy2 <= ready[rd2];
            val2 <= regs[rd2];
        end
    end

    // ring only returns results for registers allocated since the last rollback
    a_wb_to_pending: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid |-> !ready[wb.phys]
    ) else $error("phys_reg_file: writeback to ready register p%0d", wb.phys);

endmodule

`default_nettype wire

/* hdl/reg_rename.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_rename import rename_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  rename_req_t req,
    input  ring_wb_t    wb,
    input  rob_commit_t commit,
    input  logic        rollback,

    output rename_rsp_t rsp,
    output logic        none_free
);

    phys_idx_t next_free;
    phys_idx_t map_rd1;
    phys_idx_t map_rd2;

    // map stage
    logic      s1_valid;
    phys_idx_t s1_phys_wr;

    // register file stage
    logic      s2_valid;
    phys_idx_t s2_phys_wr;
    phys_idx_t s2_rd1;
    phys_idx_t s2_rd2;

    logic  prf_rdy1;
    logic  prf_rdy2;
    data_t prf_val1;
    data_t prf_val2;

    rename_map i_map (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .alloc_phys (next_free),
        .commit     (commit),
        .rollback   (rollback),
        .phys_rd1   (map_rd1),
        .phys_rd2   (map_rd2)
    );

    phys_free_list i_free (
        .clk       (clk),
        .arst_n    (arst_n),
        .alloc     (req.valid),
        .commit    (commit),
        .rollback  (rollback),
        .next_free (next_free),
        .none_free (none_free)
    );

    // ready bit drops in the same edge that maps the destination
    phys_reg_file i_prf (
        .clk        (clk),
        .arst_n     (arst_n),
        .alloc      (req.valid),
        .alloc_phys (next_free),
        .rd1        (map_rd1),
        .rd2        (map_rd2),
        .wb         (wb),
        .rollback   (rollback),
        .rdy1       (prf_rdy1),
        .rdy2       (prf_rdy2),
        .val1       (prf_val1),
        .val2       (prf_val2)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_phys_wr <= next_free;
        s2_phys_wr <= s1_phys_wr;
        s2_rd1     <= map_rd1;
        s2_rd2     <= map_rd2;
    end

    always_comb begin
        rsp.valid    = s2_valid;
        rsp.phys_rd1 = s2_rd1;
        rsp.phys_rd2 = s2_rd2;
        rsp.rdy1     = prf_rdy1;
        rsp.rdy2     = prf_rdy2;
        rsp.val1     = prf_val1;
        rsp.val2     = prf_val2;
        rsp.phys_wr  = s2_phys_wr;
    end

endmodule

`default_nettype wire

/* sim/rename_ref_model.sv */
`default_nettype none

package rename_ref_model;

`include "rename_config.svh"

    import rename_pkg::*;

    phys_idx_t                spec_map [`RN_ARCH_REGS];
    phys_idx_t                comm_map [`RN_ARCH_REGS];
    logic [`RN_PHYS_REGS-1:0] spec_free;
    logic [`RN_PHYS_REGS-1:0] comm_free;
    logic [`RN_PHYS_REGS-1:0] ready;
    data_t                    regs [`RN_PHYS_REGS];

    function automatic void reset_state();
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            spec_map[i] = phys_idx_t'(i);
            comm_map[i] = phys_idx_t'(i);
        end
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            spec_free[i] = (i >= `RN_ARCH_REGS);
            comm_free[i] = (i >= `RN_ARCH_REGS);
            regs[i]      = '0;
        end
        ready = '1;
    endfunction

    function automatic phys_idx_t lowest_free();
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            if (spec_free[i]) begin
                return phys_idx_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic logic out_of_regs();
        return ~|spec_free;
    endfunction

    // state change at one clock edge, given the inputs of the cycle it ends
    function automatic void apply_edge(rename_req_t req, ring_wb_t wb,
                                       rob_commit_t commit, logic rollback);
        phys_idx_t alloc;
        alloc = lowest_free();
        if (wb.valid) begin
            regs[wb.phys] = wb.value;
        end
        if (commit.valid) begin
            comm_map[commit.arch]      = commit.new_phys;
            comm_free[commit.new_phys] = 1'b0;
            comm_free[commit.old_phys] = 1'b1;
            spec_free[commit.old_phys] = 1'b1;
        end
        if (rollback) begin
            // committed state includes this edge's commit
            spec_map  = comm_map;
            spec_free = comm_free;
            ready     = '1;
        end else begin
            if (wb.valid) begin
                ready[wb.phys] = 1'b1;
            end
            if (req.valid) begin
                spec_map[req.wr] = alloc;
                spec_free[alloc] = 1'b0;
                ready[alloc]     = 1'b0;
            end
        end
    endfunction

endpackage

`default_nettype wire

/* sim/tb_reg_rename.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module tb_reg_rename import rename_pkg::*, rename_ref_model::*; ();

    localparam int NUM_CYCLES = 4000;
    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 32'h84c0eeeb;

    logic        clk;
    logic        arst_n;
    rename_req_t req;
    ring_wb_t    wb;
    rob_commit_t commit;
    logic        rollback;
    rename_rsp_t rsp;
    logic        none_free;

    // registers waiting for the ring, and uops waiting to retire
    phys_idx_t   pending_q [$];
    rob_commit_t rob_q [$];
    rename_rsp_t exp_q [$];

    // uop renamed last cycle, its sources are read this cycle
    rename_rsp_t half_rsp;
    logic        half_valid;

    // set when this cycle's drive queued an expected response
    logic pushed_now;
    logic rsp_due;

    int commit_pct;
    int checks;
    int errors;

    reg_rename i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .wb        (wb),
        .commit    (commit),
        .rollback  (rollback),
        .rsp       (rsp),
        .none_free (none_free)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic drive_cycle(input bit active);
        rename_req_t n_req;
        ring_wb_t    n_wb;
        rob_commit_t n_commit;
        rob_commit_t entry;
        logic        n_roll;
        logic        byp1;
        logic        byp2;
        phys_idx_t   alloc;
        int          pick;
        n_req      = '0;
        n_wb       = '0;
        n_commit   = '0;
        n_roll     = 1'b0;
        pushed_now = 1'b0;
        apply_edge(req, wb, commit, rollback);
        if (active) begin
            if (pending_q.size() > 0 && $urandom_range(99) < 50) begin
                pick        = $urandom_range(pending_q.size() - 1);
                n_wb.valid  = 1'b1;
                n_wb.phys   = pending_q[pick];
                n_wb.value  = data_t'($urandom());
                pending_q.delete(pick);
            end
            // retire only uops whose result is back
            if (rob_q.size() > 0 && ready[rob_q[0].new_phys] &&
                $urandom_range(99) < commit_pct) begin
                n_commit = rob_q.pop_front();
            end
            n_roll = ($urandom_range(249) == 0);
            if (!n_roll && !out_of_regs() && $urandom_range(99) < 70) begin
                n_req.valid = 1'b1;
                n_req.rd1   = arch_idx_t'($urandom());
                n_req.rd2   = arch_idx_t'($urandom());
                n_req.wr    = arch_idx_t'($urandom());
            end
        end
        if (half_valid) begin
            byp1          = n_wb.valid && (n_wb.phys == half_rsp.phys_rd1);
            byp2          = n_wb.valid && (n_wb.phys == half_rsp.phys_rd2);
            half_rsp.rdy1 = ready[half_rsp.phys_rd1] || byp1;
            half_rsp.rdy2 = ready[half_rsp.phys_rd2] || byp2;
            half_rsp.val1 = byp1 ? n_wb.value : regs[half_rsp.phys_rd1];
            half_rsp.val2 = byp2 ? n_wb.value : regs[half_rsp.phys_rd2];
            exp_q.push_back(half_rsp);
            pushed_now = 1'b1;
            half_valid = 1'b0;
        end
        if (n_req.valid) begin
            alloc             = lowest_free();
            half_rsp          = '0;
            half_rsp.valid    = 1'b1;
            half_rsp.phys_rd1 = spec_map[n_req.rd1];
            half_rsp.phys_rd2 = spec_map[n_req.rd2];
            half_rsp.phys_wr  = alloc;
            half_valid        = 1'b1;
            entry.valid       = 1'b1;
            entry.arch        = n_req.wr;
            entry.new_phys    = alloc;
            entry.old_phys    = spec_map[n_req.wr];
            rob_q.push_back(entry);
            pending_q.push_back(alloc);
        end
        if (n_roll) begin
            rob_q.delete();
            pending_q.delete();
        end
        req      <= n_req;
        wb       <= n_wb;
        commit   <= n_commit;
        rollback <= n_roll;
    endtask

    task automatic check_response(input rename_rsp_t exp);
        check_value("rename_rsp", "phys_rd1", 64'(exp.phys_rd1), 64'(rsp.phys_rd1));
        check_value("rename_rsp", "phys_rd2", 64'(exp.phys_rd2), 64'(rsp.phys_rd2));
        check_value("rename_rsp", "rdy1", 64'(exp.rdy1), 64'(rsp.rdy1));
        check_value("rename_rsp", "rdy2", 64'(exp.rdy2), 64'(rsp.rdy2));
        check_value("rename_rsp", "val1", 64'(exp.val1), 64'(rsp.val1));
        check_value("rename_rsp", "val2", 64'(exp.val2), 64'(rsp.val2));
        check_value("rename_rsp", "phys_wr", 64'(exp.phys_wr), 64'(rsp.phys_wr));
    endtask

    // a response is due two cycles after its uop, one after it was queued
    always @(negedge clk) begin
        if (arst_n) begin
            check_value("none_free", "flag", 64'(out_of_regs()), 64'(none_free));
            rsp_due = (exp_q.size() > (pushed_now ? 1 : 0));
            check_value("rename_rsp", "valid", 64'(rsp_due), 64'(rsp.valid));
            if (rsp_due) begin
                check_response(exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        arst_n     = 1'b0;
        req        = '0;
        wb         = '0;
        commit     = '0;
        rollback   = 1'b0;
        half_valid = 1'b0;
        half_rsp   = '0;
        pushed_now = 1'b0;
        rsp_due    = 1'b0;
        commit_pct = 60;
        checks     = 0;
        errors     = 0;
        reset_state();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            // long stretches with few commits fill the free list
            commit_pct = ((c / 400) % 2 == 1) ? 3 : 60;
            @(posedge clk);
            drive_cycle(1'b1);
        end
        repeat (4) begin
            @(posedge clk);
            drive_cycle(1'b0);
        end
        @(posedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected responses never came out", exp_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", NUM_CYCLES + 100);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/rename_map.sv
hdl/phys_free_list.sv
hdl/phys_reg_file.sv
hdl/reg_rename.sv
sim/rename_ref_model.sv
sim/tb_reg_rename.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_reg_rename
FILELIST   := sim.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
